/* design/rpc_cfg_pkg.sv */
// RPC configuration register definitions
package rpc_cfg_pkg;

  // -------------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------------

  // Bus data word and stored register word
  localparam int unsigned REG_WIDTH       = 32;
  // Register bus address
  localparam int unsigned ADDR_WIDTH      = 5;
  // Direct command as seen by the command sequencer
  localparam int unsigned CMD_WIDTH       = 19;
  // PHY delay-line tap setting
  localparam int unsigned DELAY_CFG_WIDTH = 5;

  // -------------------------------------------------------------------------
  // Register map
  // -------------------------------------------------------------------------

  localparam logic [ADDR_WIDTH-1:0] ADDR_INIT_CFG    = 5'd0;
  localparam logic [ADDR_WIDTH-1:0] ADDR_INIT_COMP   = 5'd1;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DIRECT_CMD  = 5'd2;
  localparam logic [ADDR_WIDTH-1:0] ADDR_REF_TIMER   = 5'd3;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DLY_CLK90   = 5'd4;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DLY_DQS_I   = 5'd5;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DLY_DQS_NI  = 5'd6;
  // Timing array base, one entry every 4 addresses
  localparam logic [ADDR_WIDTH-1:0] ADDR_TIMING_BASE = 5'd16;
  localparam int unsigned           NUM_TIMING_CFG   = 4;

  // Register select from address decode
  typedef enum logic [3:0] {
    SEL_INIT_CFG,
    SEL_INIT_COMP,
    SEL_DIRECT_CMD,
    SEL_REF_TIMER,
    SEL_DLY_CLK90,
    SEL_DLY_DQS_I,
    SEL_DLY_DQS_NI,
    SEL_TIMING,
    SEL_NONE
  } reg_sel_e;

  // Register bus FSM
  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } bus_state_e;

endpackage

/* design/cfg_bus_decode.sv */
// Register bus FSM and address decode
`timescale 1ns/1ps

module cfg_bus_decode (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         valid_i,
  input  logic                                         write_i,
  input  logic [rpc_cfg_pkg::ADDR_WIDTH-1:0]           addr_i,
  input  logic                                         fifo_not_full_i,
  output logic                                         ready_o,
  output logic                                         wr_en_o,
  output logic                                         rd_en_o,
  output rpc_cfg_pkg::reg_sel_e                        sel_o,
  output logic [$clog2(rpc_cfg_pkg::NUM_TIMING_CFG)-1:0] timing_idx_o
);

  localparam int unsigned IDX_WIDTH = $clog2(rpc_cfg_pkg::NUM_TIMING_CFG);

  rpc_cfg_pkg::bus_state_e state_d, state_q;
  logic [rpc_cfg_pkg::ADDR_WIDTH-1:0] timing_off;
  logic stall;

  // -------------------------------------------------------------------------
  // Address decode
  // -------------------------------------------------------------------------

  always_comb begin
    // Offset into timing array, stride of 4
    timing_off   = addr_i - rpc_cfg_pkg::ADDR_TIMING_BASE;
    timing_idx_o = timing_off[IDX_WIDTH+1:2];
    if (addr_i >= rpc_cfg_pkg::ADDR_TIMING_BASE) begin
      sel_o = rpc_cfg_pkg::SEL_TIMING;
    end else begin
      case (addr_i)
        rpc_cfg_pkg::ADDR_INIT_CFG:   sel_o = rpc_cfg_pkg::SEL_INIT_CFG;
        rpc_cfg_pkg::ADDR_INIT_COMP:  sel_o = rpc_cfg_pkg::SEL_INIT_COMP;
        rpc_cfg_pkg::ADDR_DIRECT_CMD: sel_o = rpc_cfg_pkg::SEL_DIRECT_CMD;
        rpc_cfg_pkg::ADDR_REF_TIMER:  sel_o = rpc_cfg_pkg::SEL_REF_TIMER;
        rpc_cfg_pkg::ADDR_DLY_CLK90:  sel_o = rpc_cfg_pkg::SEL_DLY_CLK90;
        rpc_cfg_pkg::ADDR_DLY_DQS_I:  sel_o = rpc_cfg_pkg::SEL_DLY_DQS_I;
        rpc_cfg_pkg::ADDR_DLY_DQS_NI: sel_o = rpc_cfg_pkg::SEL_DLY_DQS_NI;
        // Hole between 7 and 15
        default:                      sel_o = rpc_cfg_pkg::SEL_NONE;
      endcase
    end
  end

  // Command write with no free FIFO slot
  assign stall = write_i && (sel_o == rpc_cfg_pkg::SEL_DIRECT_CMD) && !fifo_not_full_i;

  // -------------------------------------------------------------------------
  // Bus FSM
  // -------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    ready_o = 1'b0;
    wr_en_o = 1'b0;
    rd_en_o = 1'b0;
    case (state_q)
      // Wait for host request
      rpc_cfg_pkg::ST_IDLE: begin
        if (valid_i) begin
          state_d = rpc_cfg_pkg::ST_BUSY;
        end
      end
      // Complete unless held off by the FIFO
      rpc_cfg_pkg::ST_BUSY: begin
        if (!stall) begin
          ready_o = 1'b1;
          wr_en_o = write_i;
          rd_en_o = !write_i;
          state_d = rpc_cfg_pkg::ST_IDLE;
        end
      end
      default: state_d = rpc_cfg_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rpc_cfg_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* design/cfg_reg_bank.sv */
// Configuration register storage
`timescale 1ns/1ps

module cfg_reg_bank (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        wr_en_i,
  input  rpc_cfg_pkg::reg_sel_e                       sel_i,
  input  logic [$clog2(rpc_cfg_pkg::NUM_TIMING_CFG)-1:0] timing_idx_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           wdata_i,
  input  logic                                        rpc_init_completed_i,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           init_cfg_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           ref_cfg_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           last_cmd_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_clk90_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_dqs_i_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_dqs_ni_o,
  output logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][rpc_cfg_pkg::REG_WIDTH-1:0] timing_cfg_o,
  output logic                                        launch_dram_init_o,
  output logic                                        launch_ref_o,
  output logic                                        init_done_o
);

  // -------------------------------------------------------------------------
  // Launch pulses
  // -------------------------------------------------------------------------

  // One cycle wide, aligned with the new config word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      launch_dram_init_o <= 1'b0;
      launch_ref_o       <= 1'b0;
    end else begin
      launch_dram_init_o <= wr_en_i && (sel_i == rpc_cfg_pkg::SEL_INIT_CFG);
      launch_ref_o       <= wr_en_i && (sel_i == rpc_cfg_pkg::SEL_REF_TIMER);
    end
  end

  // -------------------------------------------------------------------------
  // Configuration words
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_cfg_o   <= '0;
      ref_cfg_o    <= '0;
      last_cmd_o   <= '0;
      dly_clk90_o  <= '0;
      dly_dqs_i_o  <= '0;
      dly_dqs_ni_o <= '0;
      timing_cfg_o <= '0;
    end else if (wr_en_i) begin
      case (sel_i)
        rpc_cfg_pkg::SEL_INIT_CFG:   init_cfg_o   <= wdata_i;
        rpc_cfg_pkg::SEL_REF_TIMER:  ref_cfg_o    <= wdata_i;
        // Copy of last accepted command for read-back
        rpc_cfg_pkg::SEL_DIRECT_CMD: last_cmd_o   <= wdata_i;
        rpc_cfg_pkg::SEL_DLY_CLK90:  dly_clk90_o  <= wdata_i;
        rpc_cfg_pkg::SEL_DLY_DQS_I:  dly_dqs_i_o  <= wdata_i;
        rpc_cfg_pkg::SEL_DLY_DQS_NI: dly_dqs_ni_o <= wdata_i;
        rpc_cfg_pkg::SEL_TIMING:     timing_cfg_o[timing_idx_i] <= wdata_i;
        // Init-complete is read only, unmapped writes dropped
        default: begin
        end
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Init-complete flag
  // -------------------------------------------------------------------------

  // Sticky once the sequencer reports init done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_done_o <= 1'b0;
    end else if (rpc_init_completed_i) begin
      init_done_o <= 1'b1;
    end
  end

endmodule

/* design/direct_cmd_fifo.sv */
// Direct command FIFO
`timescale 1ns/1ps

module direct_cmd_fifo #(
  parameter int unsigned CMD_FIFO_DEPTH = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  logic [rpc_cfg_pkg::CMD_WIDTH-1:0] data_i,
  output logic                              not_full_o,
  output logic                              valid_o,
  output logic [rpc_cfg_pkg::CMD_WIDTH-1:0] data_o,
  input  logic                              ready_i
);

  localparam int unsigned PTR_WIDTH = $clog2(CMD_FIFO_DEPTH);
  localparam int unsigned CNT_WIDTH = $clog2(CMD_FIFO_DEPTH + 1);

  logic [rpc_cfg_pkg::CMD_WIDTH-1:0] mem_q [CMD_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic full;
  logic pop;

  // Pointer advance with wrap, any depth
  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(CMD_FIFO_DEPTH - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  // Status
  assign full    = (count_q == CNT_WIDTH'(CMD_FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign pop     = valid_o && ready_i;
  // A pop in this cycle frees the slot for a same-cycle push
  assign not_full_o = !full || pop;

  // Oldest entry, no fall-through
  assign data_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* design/cfg_read_mux.sv */
// Register read-back multiplexer
`timescale 1ns/1ps

module cfg_read_mux (
  input  logic                                        rd_en_i,
  input  rpc_cfg_pkg::reg_sel_e                       sel_i,
  input  logic [$clog2(rpc_cfg_pkg::NUM_TIMING_CFG)-1:0] timing_idx_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           init_cfg_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           ref_cfg_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           last_cmd_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_clk90_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_dqs_i_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]           dly_dqs_ni_i,
  input  logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][rpc_cfg_pkg::REG_WIDTH-1:0] timing_cfg_i,
  input  logic                                        init_done_i,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]           rdata_o,
  output logic                                        error_o
);

  // Idle bus reads as zero, no error
  always_comb begin
    rdata_o = '0;
    error_o = 1'b0;
    if (rd_en_i) begin
      case (sel_i)
        rpc_cfg_pkg::SEL_INIT_CFG:   rdata_o = init_cfg_i;
        // Flag zero-extended to the bus word
        rpc_cfg_pkg::SEL_INIT_COMP:  rdata_o = {{(rpc_cfg_pkg::REG_WIDTH-1){1'b0}}, init_done_i};
        rpc_cfg_pkg::SEL_DIRECT_CMD: rdata_o = last_cmd_i;
        rpc_cfg_pkg::SEL_REF_TIMER:  rdata_o = ref_cfg_i;
        rpc_cfg_pkg::SEL_DLY_CLK90:  rdata_o = dly_clk90_i;
        rpc_cfg_pkg::SEL_DLY_DQS_I:  rdata_o = dly_dqs_i_i;
        rpc_cfg_pkg::SEL_DLY_DQS_NI: rdata_o = dly_dqs_ni_i;
        rpc_cfg_pkg::SEL_TIMING:     rdata_o = timing_cfg_i[timing_idx_i];
        // Unmapped address
        default: begin
          rdata_o = '0;
          error_o = 1'b1;
        end
      endcase
    end
  end

endmodule

/* design/rpc_config_reg.sv */
// RPC configuration register block
`timescale 1ns/1ps

module rpc_config_reg #(
  parameter int unsigned CMD_FIFO_DEPTH = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Register bus
  input  logic                                    valid_i,
  input  logic                                    write_i,
  input  logic [rpc_cfg_pkg::ADDR_WIDTH-1:0]      addr_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       wdata_i,
  output logic                                    ready_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]       rdata_o,
  output logic                                    error_o,
  // Direct commands to the sequencer
  input  logic                                    direct_cmd_ready_i,
  output logic                                    direct_cmd_valid_o,
  output logic [rpc_cfg_pkg::CMD_WIDTH-1:0]       direct_cmd_o,
  // Init and refresh timers
  output logic                                    launch_dram_init_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]       dram_init_cfg_o,
  output logic                                    launch_ref_o,
  output logic [rpc_cfg_pkg::REG_WIDTH-1:0]       ref_cfg_o,
  // PHY delay lines and timing FSM
  output logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_clk90_dly_o,
  output logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_dqs_i_dly_o,
  output logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_dqs_ni_dly_o,
  output logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][rpc_cfg_pkg::REG_WIDTH-1:0] phy_timing_cfg_o,
  // Sequencer status
  input  logic                                    rpc_init_completed_i
);

  localparam int unsigned IDX_WIDTH = $clog2(rpc_cfg_pkg::NUM_TIMING_CFG);

  logic wr_en, rd_en;
  rpc_cfg_pkg::reg_sel_e sel;
  logic [IDX_WIDTH-1:0] timing_idx;
  logic fifo_not_full, fifo_push;
  logic init_done;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] last_cmd, dly_clk90, dly_dqs_i, dly_dqs_ni;

  // -------------------------------------------------------------------------
  // Decode
  // -------------------------------------------------------------------------

  cfg_bus_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (valid_i),
    .write_i        (write_i),
    .addr_i         (addr_i),
    .fifo_not_full_i(fifo_not_full),
    .ready_o        (ready_o),
    .wr_en_o        (wr_en),
    .rd_en_o        (rd_en),
    .sel_o          (sel),
    .timing_idx_o   (timing_idx)
  );

  // -------------------------------------------------------------------------
  // Execute
  // -------------------------------------------------------------------------

  cfg_reg_bank u_bank (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .wr_en_i             (wr_en),
    .sel_i               (sel),
    .timing_idx_i        (timing_idx),
    .wdata_i             (wdata_i),
    .rpc_init_completed_i(rpc_init_completed_i),
    .init_cfg_o          (dram_init_cfg_o),
    .ref_cfg_o           (ref_cfg_o),
    .last_cmd_o          (last_cmd),
    .dly_clk90_o         (dly_clk90),
    .dly_dqs_i_o         (dly_dqs_i),
    .dly_dqs_ni_o        (dly_dqs_ni),
    .timing_cfg_o        (phy_timing_cfg_o),
    .launch_dram_init_o  (launch_dram_init_o),
    .launch_ref_o        (launch_ref_o),
    .init_done_o         (init_done)
  );

  // Push only on accepted command writes
  assign fifo_push = wr_en && (sel == rpc_cfg_pkg::SEL_DIRECT_CMD) && fifo_not_full;

  direct_cmd_fifo #(
    .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (fifo_push),
    .data_i    (wdata_i[rpc_cfg_pkg::CMD_WIDTH-1:0]),
    .not_full_o(fifo_not_full),
    .valid_o   (direct_cmd_valid_o),
    .data_o    (direct_cmd_o),
    .ready_i   (direct_cmd_ready_i)
  );

  // Delay taps are the low bits of the stored words
  assign phy_clk90_dly_o  = dly_clk90[rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0];
  assign phy_dqs_i_dly_o  = dly_dqs_i[rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0];
  assign phy_dqs_ni_dly_o = dly_dqs_ni[rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0];

  // -------------------------------------------------------------------------
  // Result
  // -------------------------------------------------------------------------

  cfg_read_mux u_read_mux (
    .rd_en_i     (rd_en),
    .sel_i       (sel),
    .timing_idx_i(timing_idx),
    .init_cfg_i  (dram_init_cfg_o),
    .ref_cfg_i   (ref_cfg_o),
    .last_cmd_i  (last_cmd),
    .dly_clk90_i (dly_clk90),
    .dly_dqs_i_i (dly_dqs_i),
    .dly_dqs_ni_i(dly_dqs_ni),
    .timing_cfg_i(phy_timing_cfg_o),
    .init_done_i (init_done),
    .rdata_o     (rdata_o),
    .error_o     (error_o)
  );

endmodule

/* dv/cfg_reg_checker.sv */
// Register block response checker
`timescale 1ns/1ps

module cfg_reg_checker #(
  parameter int unsigned CMD_FIFO_DEPTH = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    valid_i,
  input  logic                                    write_i,
  input  logic [rpc_cfg_pkg::ADDR_WIDTH-1:0]      addr_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       wdata_i,
  input  logic                                    ready_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       rdata_i,
  input  logic                                    error_i,
  input  logic [8*16-1:0]                         name_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       exp_rdata_i,
  input  logic                                    exp_error_i,
  input  logic                                    cmd_valid_i,
  input  logic                                    cmd_ready_i,
  input  logic [rpc_cfg_pkg::CMD_WIDTH-1:0]       cmd_i,
  input  logic                                    launch_init_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       init_cfg_i,
  input  logic                                    launch_ref_i,
  input  logic [rpc_cfg_pkg::REG_WIDTH-1:0]       ref_cfg_i,
  input  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] clk90_dly_i,
  input  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] dqs_i_dly_i,
  input  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] dqs_ni_dly_i,
  input  logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][rpc_cfg_pkg::REG_WIDTH-1:0] timing_cfg_i,
  output int                                      err_count_o
);

  localparam int unsigned DW = rpc_cfg_pkg::DELAY_CFG_WIDTH;

  // Commands accepted but not yet taken by the sequencer
  logic [rpc_cfg_pkg::CMD_WIDTH-1:0] cmd_q [$];
  logic [rpc_cfg_pkg::CMD_WIDTH-1:0] exp_cmd;
  logic [31:0] init_m, ref_m, clk90_m, dqs_i_m, dqs_ni_m;
  logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][31:0] timing_m;
  logic init_pulse_m, ref_pulse_m;
  logic pop;
  int errors = 0;

  assign err_count_o = errors;

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error [%0s @%0d] %0s: expected %h, actual %h",
               name_i, addr_i, what, exp, act);
    end
  endtask

  // -------------------------------------------------------------------------
  // Edge sampling, compare before model update
  // -------------------------------------------------------------------------

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      init_m       = '0;
      ref_m        = '0;
      clk90_m      = '0;
      dqs_i_m      = '0;
      dqs_ni_m     = '0;
      timing_m     = '0;
      init_pulse_m = 1'b0;
      ref_pulse_m  = 1'b0;
      cmd_q.delete();
    end else begin
      // Pulses and the words they carry
      check_word("launch_dram_init_o", 32'(init_pulse_m), 32'(launch_init_i));
      check_word("launch_ref_o", 32'(ref_pulse_m), 32'(launch_ref_i));
      check_word("dram_init_cfg_o", init_m, init_cfg_i);
      check_word("ref_cfg_o", ref_m, ref_cfg_i);
      // PHY taps are the low bits only
      check_word("phy_clk90_dly_o", 32'(clk90_m[DW-1:0]), 32'(clk90_dly_i));
      check_word("phy_dqs_i_dly_o", 32'(dqs_i_m[DW-1:0]), 32'(dqs_i_dly_i));
      check_word("phy_dqs_ni_dly_o", 32'(dqs_ni_m[DW-1:0]), 32'(dqs_ni_dly_i));
      for (int k = 0; k < rpc_cfg_pkg::NUM_TIMING_CFG; k++) begin
        check_word("phy_timing_cfg_o", timing_m[k], timing_cfg_i[k]);
      end
      if (!valid_i && (ready_i || error_i)) begin
        errors++;
        $display("ready_o or error_o high while no request was pending");
      end
      // Downstream side
      if (cmd_valid_i != (cmd_q.size() != 0)) begin
        errors++;
        $display("direct_cmd_valid_o is %0b with %0d commands pending",
                 cmd_valid_i, cmd_q.size());
      end
      pop = cmd_valid_i && cmd_ready_i && (cmd_q.size() != 0);
      if (pop) begin
        exp_cmd = cmd_q.pop_front();
        check_word("direct_cmd_o", 32'(exp_cmd), 32'(cmd_i));
      end
      init_pulse_m = 1'b0;
      ref_pulse_m  = 1'b0;
      // Bus completion cycle
      if (ready_i) begin
        check_word("rdata_o", exp_rdata_i, rdata_i);
        check_word("error_o", 32'(exp_error_i), 32'(error_i));
        if (write_i) begin
          case (addr_i)
            5'd0: begin
              init_m       = wdata_i;
              init_pulse_m = 1'b1;
            end
            5'd3: begin
              ref_m       = wdata_i;
              ref_pulse_m = 1'b1;
            end
            5'd4: clk90_m  = wdata_i;
            5'd5: dqs_i_m  = wdata_i;
            5'd6: dqs_ni_m = wdata_i;
            5'd2: begin
              // Slot only frees up through a pop in the same cycle
              if (!pop && cmd_q.size() >= int'(CMD_FIFO_DEPTH)) begin
                errors++;
                $display("Direct command accepted while the FIFO was full");
              end
              cmd_q.push_back(wdata_i[rpc_cfg_pkg::CMD_WIDTH-1:0]);
            end
            default: begin
              // Timing entry (addr - 16) / 4
              if (addr_i >= 5'd16) begin
                timing_m[addr_i[3:2]] = wdata_i;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

/* dv/tb_rpc_config_reg.sv */
// RPC configuration register testbench
`timescale 1ns/1ps

module tb_rpc_config_reg;

  localparam int unsigned CMD_FIFO_DEPTH = 4;
  localparam int MAX_TXN     = 48;
  localparam int TIMEOUT     = 50;
  localparam int HOLD_CYCLES = 10;
  // Per-entry side actions
  localparam logic [1:0] CTL_NONE = 2'd0;
  localparam logic [1:0] CTL_INIT = 2'd1;
  localparam logic [1:0] CTL_HOLD = 2'd2;

  logic clk_i;
  logic rst_ni;
  logic valid_i;
  logic write_i;
  logic [rpc_cfg_pkg::ADDR_WIDTH-1:0] addr_i;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] wdata_i;
  logic ready_o;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] rdata_o;
  logic error_o;
  logic direct_cmd_ready_i;
  logic direct_cmd_valid_o;
  logic [rpc_cfg_pkg::CMD_WIDTH-1:0] direct_cmd_o;
  logic launch_dram_init_o;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] dram_init_cfg_o;
  logic launch_ref_o;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] ref_cfg_o;
  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_clk90_dly_o;
  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_dqs_i_dly_o;
  logic [rpc_cfg_pkg::DELAY_CFG_WIDTH-1:0] phy_dqs_ni_dly_o;
  logic [rpc_cfg_pkg::NUM_TIMING_CFG-1:0][rpc_cfg_pkg::REG_WIDTH-1:0] phy_timing_cfg_o;
  logic rpc_init_completed_i;

  // Current entry as seen by the checker
  logic [8*16-1:0] cur_name;
  logic [rpc_cfg_pkg::REG_WIDTH-1:0] exp_rdata;
  logic exp_error;
  int err_count;
  int timeouts = 0;

  // -------------------------------------------------------------------------
  // Transaction table
  // -------------------------------------------------------------------------

  logic [8*16-1:0] tbl_name [MAX_TXN];
  logic            tbl_wr [MAX_TXN];
  logic [4:0]      tbl_addr [MAX_TXN];
  logic [31:0]     tbl_wdata [MAX_TXN];
  logic [31:0]     tbl_exp_rdata [MAX_TXN];
  logic            tbl_exp_err [MAX_TXN];
  logic [1:0]      tbl_ctl [MAX_TXN];
  int n_txn;
  // Expected register contents while the table is built
  logic [31:0] shadow [11];
  logic [31:0] lcg_state;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Slot 0..6 direct registers, 7..10 timing entries, -1 unmapped
  function automatic int reg_slot(input int addr);
    if (addr <= 6) begin
      return addr;
    end
    if (addr >= 16) begin
      return 7 + (addr - 16) / 4;
    end
    return -1;
  endfunction

  task automatic add_txn(input logic [8*16-1:0] name, input logic wr, input int addr,
                         input logic [1:0] ctl);
    int slot;
    logic [31:0] data;
    slot = reg_slot(addr);
    data = wr ? lcg_next() : 32'd0;
    // Init pulse goes out ahead of this entry
    if (ctl == CTL_INIT) begin
      shadow[1] = 32'd1;
    end
    tbl_name[n_txn]  = name;
    tbl_wr[n_txn]    = wr;
    tbl_addr[n_txn]  = addr[4:0];
    tbl_wdata[n_txn] = data;
    tbl_ctl[n_txn]   = ctl;
    if (wr) begin
      // Init-complete is read only
      if (slot >= 0 && addr != 1) begin
        shadow[slot] = data;
      end
      tbl_exp_rdata[n_txn] = 32'd0;
      tbl_exp_err[n_txn]   = 1'b0;
    end else begin
      tbl_exp_rdata[n_txn] = (slot >= 0) ? shadow[slot] : 32'd0;
      tbl_exp_err[n_txn]   = (slot < 0);
    end
    n_txn++;
  endtask

  task automatic build_table();
    int a;
    lcg_state = 32'd85;
    n_txn = 0;
    for (a = 0; a < 11; a++) begin
      shadow[a] = 32'd0;
    end
    // Reset values of every mapped register
    for (a = 0; a <= 6; a++) begin
      add_txn("rst_rd", 1'b0, a, CTL_NONE);
    end
    for (a = 16; a < 32; a += 4) begin
      add_txn("rst_rd", 1'b0, a, CTL_NONE);
    end
    // Full words with pulses on 0 and 3 only
    add_txn("wr_init_cfg", 1'b1, 0, CTL_NONE);
    add_txn("rd_init_cfg", 1'b0, 0, CTL_NONE);
    for (a = 3; a <= 6; a++) begin
      add_txn("wr_cfg", 1'b1, a, CTL_NONE);
      add_txn("rd_cfg", 1'b0, a, CTL_NONE);
    end
    add_txn("wr_init_again", 1'b1, 0, CTL_NONE);
    add_txn("wr_init_comp", 1'b1, 1, CTL_NONE);
    add_txn("rd_init_comp_0", 1'b0, 1, CTL_NONE);
    add_txn("wr_hole", 1'b1, 9, CTL_NONE);
    add_txn("rd_hole", 1'b0, 9, CTL_NONE);
    // Timing array where 29 lands in entry 3
    add_txn("wr_timing", 1'b1, 16, CTL_NONE);
    add_txn("wr_timing", 1'b1, 20, CTL_NONE);
    add_txn("wr_timing", 1'b1, 24, CTL_NONE);
    add_txn("wr_timing", 1'b1, 29, CTL_NONE);
    for (a = 16; a < 32; a += 4) begin
      add_txn("rd_timing", 1'b0, a, CTL_NONE);
    end
    // Fill the FIFO, then stall until the sequencer drains
    for (a = 0; a < 4; a++) begin
      add_txn("cmd_wr", 1'b1, 2, CTL_NONE);
    end
    add_txn("cmd_rd", 1'b0, 2, CTL_NONE);
    add_txn("cmd_stall", 1'b1, 2, CTL_HOLD);
    add_txn("cmd_rd_last", 1'b0, 2, CTL_NONE);
    add_txn("rd_init_comp_1", 1'b0, 1, CTL_INIT);
    add_txn("rd_init_sticky", 1'b0, 1, CTL_NONE);
  endtask

  // -------------------------------------------------------------------------
  // Clock, DUT and checker
  // -------------------------------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  rpc_config_reg #(
    .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
  ) dut0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .valid_i             (valid_i),
    .write_i             (write_i),
    .addr_i              (addr_i),
    .wdata_i             (wdata_i),
    .ready_o             (ready_o),
    .rdata_o             (rdata_o),
    .error_o             (error_o),
    .direct_cmd_ready_i  (direct_cmd_ready_i),
    .direct_cmd_valid_o  (direct_cmd_valid_o),
    .direct_cmd_o        (direct_cmd_o),
    .launch_dram_init_o  (launch_dram_init_o),
    .dram_init_cfg_o     (dram_init_cfg_o),
    .launch_ref_o        (launch_ref_o),
    .ref_cfg_o           (ref_cfg_o),
    .phy_clk90_dly_o     (phy_clk90_dly_o),
    .phy_dqs_i_dly_o     (phy_dqs_i_dly_o),
    .phy_dqs_ni_dly_o    (phy_dqs_ni_dly_o),
    .phy_timing_cfg_o    (phy_timing_cfg_o),
    .rpc_init_completed_i(rpc_init_completed_i)
  );

  cfg_reg_checker #(
    .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
  ) mon0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_i),
    .write_i      (write_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .ready_i      (ready_o),
    .rdata_i      (rdata_o),
    .error_i      (error_o),
    .name_i       (cur_name),
    .exp_rdata_i  (exp_rdata),
    .exp_error_i  (exp_error),
    .cmd_valid_i  (direct_cmd_valid_o),
    .cmd_ready_i  (direct_cmd_ready_i),
    .cmd_i        (direct_cmd_o),
    .launch_init_i(launch_dram_init_o),
    .init_cfg_i   (dram_init_cfg_o),
    .launch_ref_i (launch_ref_o),
    .ref_cfg_i    (ref_cfg_o),
    .clk90_dly_i  (phy_clk90_dly_o),
    .dqs_i_dly_i  (phy_dqs_i_dly_o),
    .dqs_ni_dly_i (phy_dqs_ni_dly_o),
    .timing_cfg_i (phy_timing_cfg_o),
    .err_count_o  (err_count)
  );

  // -------------------------------------------------------------------------
  // Driving loop
  // -------------------------------------------------------------------------

  // Ready sampled at the edge and the sequencer released mid-wait on a hold entry
  task automatic wait_ready(input logic [1:0] ctl, input logic [8*16-1:0] name);
    int cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    do begin
      @(posedge clk_i);
      cycles++;
      seen = ready_o;
      if (ctl == CTL_HOLD && cycles == HOLD_CYCLES) begin
        direct_cmd_ready_i <= 1'b1;
      end
    end while (!seen && cycles < TIMEOUT);
    if (!seen) begin
      timeouts++;
      $display("Timeout: no ready_o for %0s after %0d cycles", name, TIMEOUT);
    end
  endtask

  task automatic wait_fifo_drain();
    int cycles;
    logic pending;
    cycles  = 0;
    pending = 1'b1;
    do begin
      @(posedge clk_i);
      cycles++;
      pending = direct_cmd_valid_o;
    end while (pending && cycles < TIMEOUT);
    if (pending) begin
      timeouts++;
      $display("Timeout: direct command FIFO did not drain");
    end
  endtask

  initial begin
    int i;
    valid_i              <= 1'b0;
    write_i              <= 1'b0;
    addr_i               <= '0;
    wdata_i              <= '0;
    direct_cmd_ready_i   <= 1'b0;
    rpc_init_completed_i <= 1'b0;
    cur_name             <= '0;
    exp_rdata            <= '0;
    exp_error            <= 1'b0;
    rst_ni               <= 1'b0;
    build_table();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (i = 0; i < n_txn; i++) begin
      @(posedge clk_i);
      // Single-cycle init-complete report
      if (tbl_ctl[i] == CTL_INIT) begin
        rpc_init_completed_i <= 1'b1;
        @(posedge clk_i);
        rpc_init_completed_i <= 1'b0;
      end
      cur_name  <= tbl_name[i];
      exp_rdata <= tbl_exp_rdata[i];
      exp_error <= tbl_exp_err[i];
      valid_i   <= 1'b1;
      write_i   <= tbl_wr[i];
      addr_i    <= tbl_addr[i];
      wdata_i   <= tbl_wdata[i];
      wait_ready(tbl_ctl[i], tbl_name[i]);
      valid_i <= 1'b0;
      write_i <= 1'b0;
    end
    wait_fifo_drain();
    @(posedge clk_i);
    @(negedge clk_i);
    $display("Run done: %0d transactions, %0d check errors, %0d timeouts",
             n_txn, err_count, timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
design/rpc_cfg_pkg.sv
design/cfg_bus_decode.sv
design/cfg_reg_bank.sv
design/direct_cmd_fifo.sv
design/cfg_read_mux.sv
design/rpc_config_reg.sv
dv/cfg_reg_checker.sv
dv/tb_rpc_config_reg.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the register block simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_rpc_config_reg \
  -f files.f

out="$(./obj_dir/Vtb_rpc_config_reg)"
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
else
  exit 1
fi
